// ==== sim.f ====
logic/me_fetch_pkg.sv
logic/ref_bank.sv
logic/ref_window.sv
logic/cur_buffer.sv
logic/fetch_ctrl.sv
logic/me_fetch_top.sv
dv/me_fetch_tb.sv

// ==== Makefile ====
# Verilator flow for the motion estimator fetch front end

VERILATOR  ?= verilator
FILELIST   ?= sim.f
TB_TOP     ?= me_fetch_tb
LINT_TOP   ?= me_fetch_top
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --timing
LINT_FLAGS ?= -Wall
FAIL_MSG   ?= CHECKS FAILED
PASS_MSG   ?= ALL CHECKS PASSED

SRCS    := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

sim: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation ended without a pass line"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/me_fetch_tb.sv ====
`timescale 1ns/10ps

module me_fetch_tb;
    import me_fetch_pkg::*;

    localparam int CLK_PERIOD      = 20;
    localparam int DRIVE_DELAY     = 2;
    localparam int RESET_CYCLES    = 10;
    localparam int LINE_CYCLES     = (BLOCKS_PER_LINE + 1) * BANK_DEPTH;
    localparam int FIRST_RUN_SLOT  = NUM_BANKS - 1;
    localparam int DRAIN_START     = BLOCKS_PER_LINE * BANK_DEPTH;   // First drain cycle in a line
    localparam int FIRST_VALID     = FIRST_RUN_SLOT * BANK_DEPTH + 1;
    localparam int VALID_SLOTS     = BLOCKS_PER_LINE + 1 - FIRST_RUN_SLOT;
    localparam int IDLE_PCT        = 30;
    // Fill 1 line, full lines up to 3, gaps about 2 lines of clocks, loads 1 line
    localparam int TEST_CYCLES     = RESET_CYCLES + 7 * LINE_CYCLES;
    localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;
    localparam logic [31:0] LCG_SEED = 32'hdeb3;

    logic       clk;
    logic       rst;
    logic       en;
    row_word_t  ref_in;
    mem_addr_t  ref_mem_addr;
    row_word_t  cur_in;
    mem_addr_t  cur_mem_addr;
    ref_win_t   ref_win;
    logic       ref_valid;
    cur_block_t cur_block;
    logic       cur_valid;
    logic       next_block;

    int          en_cnt;        // Enabled cycles completed since reset
    int          sample_idx;    // Enabled cycle shown at the last sample
    int          words_loaded;
    int          loads_done;
    int          load_left;
    logic        cur_due;
    logic        obs_valid;
    logic        obs_nb;
    logic        obs_cur_valid;
    mem_addr_t   obs_ref_addr;
    logic [31:0] lcg_state;
    int          err_count;
    string       cur_test;

    me_fetch_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .en           (en),
        .ref_in       (ref_in),
        .ref_mem_addr (ref_mem_addr),
        .cur_in       (cur_in),
        .cur_mem_addr (cur_mem_addr),
        .ref_win      (ref_win),
        .ref_valid    (ref_valid),
        .cur_block    (cur_block),
        .cur_valid    (cur_valid),
        .next_block   (next_block)
    );

    function automatic logic [31:0] lcg_step(logic [31:0] x);
        return x * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic row_word_t ref_word(mem_addr_t a);
        logic [31:0] h;
        h = lcg_step(a ^ LCG_SEED);
        return {h, lcg_step(h)};
    endfunction

    // Halves swapped so the two memories never return the same data
    function automatic row_word_t cur_word(mem_addr_t a);
        logic [31:0] h;
        h = lcg_step({a[15:0], a[31:16]} ^ 32'h5a5a_c3c3);
        return {lcg_step(h), h ^ a};
    endfunction

    // Both memories answer in the same cycle
    assign ref_in = ref_word(ref_mem_addr);
    assign cur_in = cur_word(cur_mem_addr);

    function automatic int line_of(int idx);
        return idx / LINE_CYCLES;
    endfunction

    function automatic int slot_of(int idx);
        return (idx % LINE_CYCLES) / BANK_DEPTH;
    endfunction

    function automatic int row_of(int idx);
        return (idx % LINE_CYCLES) % BANK_DEPTH;
    endfunction

    function automatic mem_addr_t word_addr(int line, int blk, int row);
        return mem_addr_t'(((line * BLOCKS_PER_LINE + blk) * BANK_DEPTH + row) * WORD_BYTES);
    endfunction

    // Window of enabled cycle idx holds blocks slot-3 .. slot-1, the last one cut to 7 pixels
    function automatic win_row_t exp_window(int idx);
        row_word_t w0;
        row_word_t w1;
        row_word_t w2;
        int        line;
        int        slot;
        int        row;
        line = line_of(idx);
        slot = slot_of(idx);
        row  = row_of(idx);
        w0 = ref_word(word_addr(line, slot - 3, row));
        w1 = ref_word(word_addr(line, slot - 2, row));
        w2 = ref_word(word_addr(line, slot - 1, row));
        return {w0, w1, w2[63:8]};
    endfunction

    // Address after idx enabled cycles, no step during drain
    function automatic mem_addr_t exp_ref_addr(int idx);
        int pos;
        int words;
        pos   = idx % LINE_CYCLES;
        words = line_of(idx) * DRAIN_START + ((pos < DRAIN_START) ? pos : DRAIN_START);
        return mem_addr_t'(words * WORD_BYTES);
    endfunction

    function automatic cur_block_t exp_block(int load);
        cur_block_t blk;
        mem_addr_t  base;
        base = mem_addr_t'(load * CUR_ROWS * WORD_BYTES);
        for (int r = 0; r < CUR_ROWS; r++) begin
            blk[r] = cur_word(base + mem_addr_t'(r * WORD_BYTES));
        end
        return blk;
    endfunction

    task automatic stop_on_failure();
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_equal(string what, logic [511:0] exp, logic [511:0] act);
        if (act !== exp) begin
            err_count++;
            $display("ERR %s %s: expected %0h actual %0h", cur_test, what, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic draw_enable(output logic v);
        int r;
        lcg_state = lcg_step(lcg_state);
        r = int'(lcg_state[31:16]) % 100;
        v = (r >= IDLE_PCT);
    endtask

    // One clock: drive en, check all outputs against the model, then advance the model
    task automatic run_cycle(input logic en_val);
        logic exp_nb;
        logic exp_valid;
        @(posedge clk);
        #DRIVE_DELAY;
        en = en_val;
        @(negedge clk);
        exp_nb    = en_val && slot_of(en_cnt) >= FIRST_RUN_SLOT &&
                    row_of(en_cnt) == CUR_LOAD_OFFSET;
        exp_valid = en_val && en_cnt > 0 && slot_of(en_cnt - 1) >= FIRST_RUN_SLOT;
        obs_valid     = ref_valid;
        obs_nb        = next_block;
        obs_cur_valid = cur_valid;
        obs_ref_addr  = ref_mem_addr;
        check_equal("next_block", 512'(exp_nb), 512'(next_block));
        check_equal("ref_valid", 512'(exp_valid), 512'(ref_valid));
        if (exp_valid) begin
            check_equal("ref_win.row", 512'(row_of(en_cnt - 1)), 512'(ref_win.row));
            check_equal("ref_win.pix", 512'(exp_window(en_cnt - 1)), 512'(ref_win.pix));
        end
        check_equal("ref_mem_addr", 512'(exp_ref_addr(en_cnt)), 512'(ref_mem_addr));
        check_equal("cur_mem_addr", 512'(words_loaded * WORD_BYTES), 512'(cur_mem_addr));
        check_equal("cur_valid", 512'(en_val && cur_due), 512'(cur_valid));
        if (en_val && cur_due) begin
            check_equal("cur_block", 512'(exp_block(loads_done)), 512'(cur_block));
        end
        if (en_val) begin
            sample_idx = en_cnt;
            if (cur_due) begin
                cur_due = 1'b0;
                loads_done++;
            end
            if (load_left > 0) begin
                words_loaded++;
                load_left--;
                cur_due = (load_left == 0);
            end
            if (exp_nb) begin
                load_left = CUR_ROWS;
            end
            en_cnt++;
        end
    endtask

    task automatic test_reset();
        cur_test = "test_reset";
        for (int i = 0; i < RESET_CYCLES - 1; i++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            en = (i > 0);   // Enabled during reset, which must still win
            @(negedge clk);
            if (i > 0) begin
                check_equal("ref_valid", 512'(1'b0), 512'(ref_valid));
                check_equal("cur_valid", 512'(1'b0), 512'(cur_valid));
                check_equal("next_block", 512'(1'b0), 512'(next_block));
                check_equal("ref_mem_addr", 512'(0), 512'(ref_mem_addr));
                check_equal("cur_mem_addr", 512'(0), 512'(cur_mem_addr));
            end
        end
        @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;
        en  = 1'b0;
        @(negedge clk);
        check_equal("ref_valid", 512'(1'b0), 512'(ref_valid));
        check_equal("cur_valid", 512'(1'b0), 512'(cur_valid));
        check_equal("next_block", 512'(1'b0), 512'(next_block));
        check_equal("ref_mem_addr", 512'(0), 512'(ref_mem_addr));
        check_equal("cur_mem_addr", 512'(0), 512'(cur_mem_addr));
    endtask

    task automatic test_fill_latency();
        int        waited;
        row_word_t w2;
        win_row_t  exp_pix;
        cur_test = "test_fill_latency";
        waited   = 0;
        do begin
            run_cycle(1'b1);
            waited++;
        end while (!obs_valid && waited < 2 * FIRST_VALID);
        if (!obs_valid) begin
            $display("ref_valid never rose within %0d enabled cycles", waited);
            stop_on_failure();
        end else begin
            w2      = ref_word(mem_addr_t'(2 * BANK_DEPTH * WORD_BYTES));
            exp_pix = {ref_word(32'h0), ref_word(mem_addr_t'(BANK_DEPTH * WORD_BYTES)), w2[63:8]};
            check_equal("first valid cycle", 512'(FIRST_VALID), 512'(sample_idx));
            check_equal("first row", 512'(0), 512'(ref_win.row));
            check_equal("first window", 512'(exp_pix), 512'(ref_win.pix));
        end
    endtask

    task automatic test_full_line();
        int        pos;
        int        step;
        int        valid_rows;
        mem_addr_t prev_addr;
        cur_test = "test_full_line";
        run_cycle(1'b1);
        while (en_cnt % LINE_CYCLES != 0) begin
            run_cycle(1'b1);
        end
        prev_addr = obs_ref_addr;
        for (int l = 0; l < 2; l++) begin
            valid_rows = 0;
            for (int c = 0; c < LINE_CYCLES; c++) begin
                run_cycle(1'b1);
                pos  = sample_idx % LINE_CYCLES;
                step = (((pos + LINE_CYCLES - 1) % LINE_CYCLES) < DRAIN_START) ? WORD_BYTES : 0;
                check_equal("ref_mem_addr step", 512'(prev_addr + mem_addr_t'(step)),
                            512'(obs_ref_addr));
                if (pos == 1) begin
                    check_equal("ref_valid after drain", 512'(1'b0), 512'(obs_valid));
                end
                if (obs_valid) begin
                    valid_rows++;
                end
                prev_addr = obs_ref_addr;
            end
            check_equal("valid rows per line", 512'(VALID_SLOTS * BANK_DEPTH), 512'(valid_rows));
        end
    endtask

    task automatic test_enable_gaps();
        int   target;
        int   idle;
        int   valid_rows;
        logic v;
        cur_test   = "test_enable_gaps";
        target     = en_cnt + LINE_CYCLES;
        idle       = 0;
        valid_rows = 0;
        while (en_cnt < target) begin
            draw_enable(v);
            run_cycle(v);
            if (!v) begin
                idle++;
                check_equal("idle ref_valid", 512'(1'b0), 512'(obs_valid));
                check_equal("idle next_block", 512'(1'b0), 512'(obs_nb));
                check_equal("idle cur_valid", 512'(1'b0), 512'(obs_cur_valid));
            end else if (obs_valid) begin
                valid_rows++;
            end
        end
        if (idle == 0) begin
            $display("The enable pattern produced no idle cycles");
            stop_on_failure();
        end
        check_equal("valid rows per line", 512'(VALID_SLOTS * BANK_DEPTH), 512'(valid_rows));
    endtask

    task automatic test_cur_load();
        int   nb_count;
        int   cv_count;
        int   nb_idx;
        logic pending;
        cur_test = "test_cur_load";
        nb_count = 0;
        cv_count = 0;
        nb_idx   = 0;
        pending  = 1'b0;
        for (int c = 0; c < LINE_CYCLES; c++) begin
            run_cycle(1'b1);
            if (obs_nb) begin
                nb_count++;
                check_equal("next_block while loading", 512'(1'b0), 512'(pending));
                check_equal("next_block row", 512'(CUR_LOAD_OFFSET), 512'(row_of(sample_idx)));
                nb_idx  = sample_idx;
                pending = 1'b1;
            end
            if (obs_cur_valid) begin
                cv_count++;
                check_equal("cur_valid without request", 512'(1'b1), 512'(pending));
                check_equal("cur_valid delay", 512'(CUR_ROWS + 1), 512'(sample_idx - nb_idx));
                pending = 1'b0;
            end
        end
        check_equal("next_block count", 512'(VALID_SLOTS), 512'(nb_count));
        check_equal("cur_valid count", 512'(VALID_SLOTS), 512'(cv_count));
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: the run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        stop_on_failure();
    end

    initial begin
        rst          = 1'b1;
        en           = 1'b0;
        lcg_state    = LCG_SEED;
        en_cnt       = 0;
        sample_idx   = 0;
        words_loaded = 0;
        loads_done   = 0;
        load_left    = 0;
        cur_due      = 1'b0;
        err_count    = 0;
        cur_test     = "init";
        test_reset();
        test_fill_latency();
        test_full_line();
        test_enable_gaps();
        test_cur_load();
        if (err_count == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            stop_on_failure();
        end
    end

endmodule

// ==== logic/me_fetch_top.sv ====
`timescale 1ns/10ps

module me_fetch_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     en,
    input  me_fetch_pkg::row_word_t  ref_in,
    output me_fetch_pkg::mem_addr_t  ref_mem_addr,
    input  me_fetch_pkg::row_word_t  cur_in,
    output me_fetch_pkg::mem_addr_t  cur_mem_addr,
    output me_fetch_pkg::ref_win_t   ref_win,
    output logic                     ref_valid,
    output me_fetch_pkg::cur_block_t cur_block,
    output logic                     cur_valid,
    output logic                     next_block
);
    import me_fetch_pkg::*;

    bank_addr_t bank_addr;
    bank_sel_t  bank_we;
    bank_sel_t  read_sel;
    bank_addr_t win_row;
    win_row_t   win_pix;

    assign ref_win = '{row: win_row, pix: win_pix};

    fetch_ctrl i_ctrl (
        .clk          (clk),
        .rst          (rst),
        .en           (en),
        .bank_addr    (bank_addr),
        .bank_we      (bank_we),
        .read_sel     (read_sel),
        .ref_mem_addr (ref_mem_addr),
        .ref_valid    (ref_valid),
        .win_row      (win_row),
        .next_block   (next_block)
    );

    ref_window i_window (
        .clk       (clk),
        .en        (en),
        .bank_addr (bank_addr),
        .bank_we   (bank_we),
        .read_sel  (read_sel),
        .ref_in    (ref_in),
        .pix       (win_pix)
    );

    cur_buffer i_cur (
        .clk          (clk),
        .rst          (rst),
        .en           (en),
        .next_block   (next_block),
        .cur_in       (cur_in),
        .cur_mem_addr (cur_mem_addr),
        .cur_block    (cur_block),
        .cur_valid    (cur_valid)
    );

endmodule

// ==== logic/fetch_ctrl.sv ====
`timescale 1ns/10ps

module fetch_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     en,
    output me_fetch_pkg::bank_addr_t bank_addr,
    output me_fetch_pkg::bank_sel_t  bank_we,
    output me_fetch_pkg::bank_sel_t  read_sel,
    output me_fetch_pkg::mem_addr_t  ref_mem_addr,
    output logic                     ref_valid,
    output me_fetch_pkg::bank_addr_t win_row,
    output logic                     next_block
);
    import me_fetch_pkg::*;

    ctrl_state_t state;
    slot_cnt_t   slot;
    bank_sel_t   wr_ptr;
    logic        slot_end;
    logic        valid_q;

    assign slot_end = (bank_addr == bank_addr_t'(BANK_DEPTH - 1));

    // Row counter, shared address of all banks
    always_ff @(posedge clk) begin
        if (rst) begin
            bank_addr <= '0;
        end else if (en) begin
            bank_addr <= slot_end ? '0 : bank_addr + 1'b1;
        end
    end

    // Line phases
    // Fill covers the first NUM_BANKS-1 slots, drain adds one slot after the last write
    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ST_FILL;
            slot   <= '0;
            wr_ptr <= bank_sel_t'(1);
        end else if (en && slot_end) begin
            case (state)
                ST_FILL: begin
                    slot   <= slot + 1'b1;
                    wr_ptr <= {wr_ptr[NUM_BANKS-2:0], wr_ptr[NUM_BANKS-1]};
                    if (slot == slot_cnt_t'(NUM_BANKS - 2)) begin
                        state <= ST_RUN;
                    end
                end
                ST_RUN: begin
                    slot   <= slot + 1'b1;
                    wr_ptr <= {wr_ptr[NUM_BANKS-2:0], wr_ptr[NUM_BANKS-1]};
                    if (slot == slot_cnt_t'(BLOCKS_PER_LINE - 1)) begin
                        state <= ST_DRAIN;
                    end
                end
                ST_DRAIN: begin
                    slot   <= '0;
                    wr_ptr <= bank_sel_t'(1);   // New line restarts at bank 0
                    state  <= ST_FILL;
                end
                default: begin
                    state <= ST_FILL;
                end
            endcase
        end
    end

    assign bank_we = (state == ST_DRAIN) ? '0 : wr_ptr;

    // Read side trails by one cycle to line up with bank data
    always_ff @(posedge clk) begin
        if (rst) begin
            read_sel <= '0;
            valid_q  <= 1'b0;
        end else if (en) begin
            read_sel <= wr_ptr;
            valid_q  <= (state != ST_FILL);
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            win_row <= bank_addr;
        end
    end

    assign ref_valid = valid_q && en;

    // One word per written row, frozen through the drain slot
    always_ff @(posedge clk) begin
        if (rst) begin
            ref_mem_addr <= '0;
        end else if (en && state != ST_DRAIN) begin
            ref_mem_addr <= ref_mem_addr + mem_addr_t'(WORD_BYTES);
        end
    end

    assign next_block = en && (state != ST_FILL) &&
                        (bank_addr == bank_addr_t'(CUR_LOAD_OFFSET));

    a_we_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(bank_we))
        else $error("bank_we not one-hot: %b", bank_we);

    a_addr_range: assert property (@(posedge clk) disable iff (rst)
        bank_addr <= bank_addr_t'(BANK_DEPTH - 1))
        else $error("bank_addr out of range: %0d", bank_addr);

endmodule

// ==== logic/cur_buffer.sv ====
`timescale 1ns/10ps

module cur_buffer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     en,
    input  logic                     next_block,
    input  me_fetch_pkg::row_word_t  cur_in,
    output me_fetch_pkg::mem_addr_t  cur_mem_addr,
    output me_fetch_pkg::cur_block_t cur_block,
    output logic                     cur_valid
);
    import me_fetch_pkg::*;

    logic                        loading;
    logic [$clog2(CUR_ROWS)-1:0] load_cnt;
    logic                        last_word;
    logic                        done;

    assign last_word = (load_cnt == ($clog2(CUR_ROWS))'(CUR_ROWS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            loading      <= 1'b0;
            load_cnt     <= '0;
            done         <= 1'b0;
            cur_mem_addr <= '0;
        end else if (en) begin
            done <= loading && last_word;   // One cycle after the last word
            if (next_block) begin
                loading  <= 1'b1;
                load_cnt <= '0;
            end else if (loading) begin
                load_cnt     <= load_cnt + 1'b1;
                cur_mem_addr <= cur_mem_addr + mem_addr_t'(WORD_BYTES);
                if (last_word) begin
                    loading <= 1'b0;
                end
            end
        end
    end

    // Rows enter at the bottom and move up, so row 0 ends in the top word
    always_ff @(posedge clk) begin
        if (en && loading) begin
            cur_block <= {cur_block[1:CUR_ROWS-1], cur_in};
        end
    end

    assign cur_valid = done && en;

    // Slot spacing in fetch_ctrl leaves room for a full load
    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        next_block |-> !loading)
        else $error("next_block during a current block load");

endmodule

// ==== logic/ref_window.sv ====
`timescale 1ns/10ps

module ref_window (
    input  logic                     clk,
    input  logic                     en,
    input  me_fetch_pkg::bank_addr_t bank_addr,
    input  me_fetch_pkg::bank_sel_t  bank_we,
    input  me_fetch_pkg::bank_sel_t  read_sel,
    input  me_fetch_pkg::row_word_t  ref_in,
    output me_fetch_pkg::win_row_t   pix
);
    import me_fetch_pkg::*;

    row_word_t q [NUM_BANKS];

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        ref_bank i_bank (
            .clk  (clk),
            .en   (en),
            .addr (bank_addr),   // All banks share one address
            .we   (bank_we[i]),
            .d    (ref_in),
            .q    (q[i])
        );
    end

    // The selected bank is the one being written, the window is the three after it
    always_comb begin
        pix = '0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            if (read_sel[i]) begin
                pix = {q[(i + 1) % NUM_BANKS],
                       q[(i + 2) % NUM_BANKS],
                       q[(i + 3) % NUM_BANKS][$bits(row_word_t)-1:$bits(pixel_t)]};
            end
        end
    end

    // Two set bits would merge two windows in the loop above
    a_read_sel_onehot: assert property (@(posedge clk)
        !$isunknown(read_sel) |-> $onehot0(read_sel))
        else $error("read_sel not one-hot: %b", read_sel);

endmodule

// ==== logic/ref_bank.sv ====
`timescale 1ns/10ps

module ref_bank (
    input  logic                    clk,
    input  logic                    en,
    input  me_fetch_pkg::bank_addr_t addr,
    input  logic                    we,
    input  me_fetch_pkg::row_word_t d,
    output me_fetch_pkg::row_word_t q
);
    import me_fetch_pkg::*;

    row_word_t mem [BANK_DEPTH];

    // Behavioral stand-in for the single-port macro
    // Old content comes out on a write cycle
    always_ff @(posedge clk) begin
        if (en) begin
            q <= mem[addr];
            if (we) begin
                mem[addr] <= d;
            end
        end
    end

endmodule

// ==== logic/me_fetch_pkg.sv ====
package me_fetch_pkg;

    localparam int BANK_DEPTH      = 23;  // Rows per block column
    localparam int NUM_BANKS       = 4;
    localparam int BLOCKS_PER_LINE = 6;   // Write slots per picture line
    localparam int CUR_ROWS        = 8;
    localparam int CUR_LOAD_OFFSET = 8;   // Row at which the current block is requested
    localparam int WORD_BYTES      = 8;

    typedef logic [7:0] pixel_t;

    // Leftmost pixel in the top byte
    typedef logic [63:0] row_word_t;

    // 23 pixels: two full words plus 7 pixels of a third
    typedef logic [183:0] win_row_t;

    typedef logic [$clog2(BANK_DEPTH)-1:0] bank_addr_t;
    typedef logic [NUM_BANKS-1:0]          bank_sel_t;   // One-hot
    typedef logic [31:0]                   mem_addr_t;
    typedef logic [9:0]                    slot_cnt_t;

    // Row 0 sits in the top bits
    typedef row_word_t [0:CUR_ROWS-1] cur_block_t;

    typedef enum logic [1:0] {
        ST_FILL,   // First three slots, window not complete yet
        ST_RUN,
        ST_DRAIN   // Extra slot, nothing written
    } ctrl_state_t;

    typedef struct packed {
        bank_addr_t row;
        win_row_t   pix;
    } ref_win_t;

endpackage
